//--- project.f
source/lsq_pkg.sv
source/ls_dispatch_if.sv
source/ls_req_if.sv
source/data_ram.sv
source/ls_unit.sv
source/ls_buffer.sv
source/lsq_top.sv
tb/tb_lsq.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module tb_lsq -o tb_lsq > build.log 2>&1 &&
./obj_dir/tb_lsq > sim.log 2>&1 ||
echo "build or run of the simulation failed, see build.log and sim.log"
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb/tb_lsq.sv
`timescale 1ns/1ps

module tb_lsq;

    logic                clk;
    logic                rst_n;
    logic                disp_ena;
    lsq_pkg::ls_op_t     disp_op;
    lsq_pkg::data_t      disp_v1;
    lsq_pkg::data_t      disp_v2;
    lsq_pkg::rob_tag_t   disp_q1;
    lsq_pkg::rob_tag_t   disp_q2;
    lsq_pkg::data_t      disp_imm;
    lsq_pkg::rob_tag_t   disp_rob_id;
    logic                full;
    logic                alu_valid;
    lsq_pkg::rob_tag_t   alu_tag;
    lsq_pkg::data_t      alu_result;
    logic                commit_valid;
    lsq_pkg::rob_tag_t   commit_tag;
    logic                flush;
    lsq_pkg::rob_tag_t   store_commit_tag;
    logic                ls_valid;
    lsq_pkg::rob_tag_t   ls_tag;
    lsq_pkg::data_t      ls_result;

    int             checks = 0;
    int             errors = 0;
    logic [15:0]    lfsr_state = 16'd40;
    // word left at 0x40 by the store test
    lsq_pkg::data_t word_a;

    lsq_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .disp_ena         (disp_ena),
        .disp_op          (disp_op),
        .disp_v1          (disp_v1),
        .disp_v2          (disp_v2),
        .disp_q1          (disp_q1),
        .disp_q2          (disp_q2),
        .disp_imm         (disp_imm),
        .disp_rob_id      (disp_rob_id),
        .full             (full),
        .alu_valid        (alu_valid),
        .alu_tag          (alu_tag),
        .alu_result       (alu_result),
        .commit_valid     (commit_valid),
        .commit_tag       (commit_tag),
        .flush            (flush),
        .store_commit_tag (store_commit_tag),
        .ls_valid         (ls_valid),
        .ls_tag           (ls_tag),
        .ls_result        (ls_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic rand_word(output lsq_pkg::data_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // byte or half picked by offset, then sign or zero filled
    function automatic lsq_pkg::data_t load_expect(input lsq_pkg::ls_op_t op,
            input lsq_pkg::data_t word, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            lsq_pkg::lb:  return {{24{b[7]}}, b};
            lsq_pkg::lbu: return {24'd0, b};
            lsq_pkg::lh:  return {{16{h[15]}}, h};
            lsq_pkg::lhu: return {16'd0, h};
            default:      return word;
        endcase
    endfunction

    task automatic check_data(input string name, input lsq_pkg::data_t got,
            input lsq_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input lsq_pkg::rob_tag_t got,
            input lsq_pkg::rob_tag_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic dispatch(input lsq_pkg::ls_op_t op, input lsq_pkg::rob_tag_t tag,
            input lsq_pkg::data_t v1, input lsq_pkg::rob_tag_t q1,
            input lsq_pkg::data_t v2, input lsq_pkg::data_t imm);
        disp_ena    = 1'b1;
        disp_op     = op;
        disp_rob_id = tag;
        disp_v1     = v1;
        disp_q1     = q1;
        disp_v2     = v2;
        disp_q2     = lsq_pkg::no_tag;
        disp_imm    = imm;
        @(negedge clk);
        disp_ena    = 1'b0;
    endtask

    task automatic commit(input lsq_pkg::rob_tag_t tag);
        commit_valid = 1'b1;
        commit_tag   = tag;
        @(negedge clk);
        commit_valid = 1'b0;
        commit_tag   = lsq_pkg::no_tag;
    endtask

    task automatic expect_commit_req(input lsq_pkg::rob_tag_t exp_tag);
        int n;
        n = 0;
        while (store_commit_tag == lsq_pkg::no_tag && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (store_commit_tag != lsq_pkg::no_tag) begin
            check_tag("store_commit_tag", store_commit_tag, exp_tag);
            @(negedge clk);
        end else begin
            $display("no commit request for tag %0d within 50 cycles", exp_tag);
            errors++;
        end
    endtask

    task automatic expect_result(input lsq_pkg::rob_tag_t exp_tag,
            input lsq_pkg::data_t exp_data);
        int n;
        n = 0;
        while (!ls_valid && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (ls_valid) begin
            check_tag("ls_tag", ls_tag, exp_tag);
            check_data("ls_result", ls_result, exp_data);
            @(negedge clk);
        end else begin
            $display("no load/store result for tag %0d within 50 cycles", exp_tag);
            errors++;
        end
    endtask

    // nothing may come out of the buffer or the unit
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("ls_valid", ls_valid, 1'b0);
            check_tag("store_commit_tag", store_commit_tag, lsq_pkg::no_tag);
        end
    endtask

    task automatic store_word(input lsq_pkg::rob_tag_t tag, input lsq_pkg::data_t addr,
            input lsq_pkg::data_t w);
        dispatch(lsq_pkg::sw, tag, addr, lsq_pkg::no_tag, w, '0);
        expect_commit_req(tag);
        commit(tag);
        expect_result(tag, '0);
    endtask

    task automatic run_load(input lsq_pkg::ls_op_t op, input lsq_pkg::rob_tag_t tag,
            input lsq_pkg::data_t addr, input lsq_pkg::data_t imm,
            input lsq_pkg::data_t exp);
        dispatch(op, tag, addr, lsq_pkg::no_tag, '0, imm);
        expect_result(tag, exp);
    endtask

    task automatic test_reset();
        check_bit("full", full, 1'b0);
        check_bit("ls_valid", ls_valid, 1'b0);
        check_tag("store_commit_tag", store_commit_tag, lsq_pkg::no_tag);
    endtask

    task automatic test_store_load();
        lsq_pkg::data_t w;
        rand_word(w);
        word_a = w;
        store_word(4'd3, 32'h40, w);
        run_load(lsq_pkg::lw, 4'd4, 32'h40, '0, w);
        for (int off = 0; off < 4; off++) begin
            run_load(lsq_pkg::lb, 4'd4, 32'h40, lsq_pkg::data_t'(off),
                     load_expect(lsq_pkg::lb, w, 2'(off)));
            run_load(lsq_pkg::lbu, 4'd4, 32'h40, lsq_pkg::data_t'(off),
                     load_expect(lsq_pkg::lbu, w, 2'(off)));
        end
        for (int off = 0; off < 4; off += 2) begin
            run_load(lsq_pkg::lh, 4'd4, 32'h40, lsq_pkg::data_t'(off),
                     load_expect(lsq_pkg::lh, w, 2'(off)));
            run_load(lsq_pkg::lhu, 4'd4, 32'h40, lsq_pkg::data_t'(off),
                     load_expect(lsq_pkg::lhu, w, 2'(off)));
        end
    endtask

    task automatic test_alu_wakeup();
        lsq_pkg::data_t w;
        rand_word(w);
        store_word(4'd1, 32'h88, w);
        // base arrives later on the alu bus
        dispatch(lsq_pkg::lw, 4'd2, 32'hdead_0000, 4'd5, '0, 32'h8);
        check_quiet(10);
        alu_valid  = 1'b1;
        alu_tag    = 4'd5;
        alu_result = 32'h80;
        @(negedge clk);
        alu_valid  = 1'b0;
        alu_tag    = lsq_pkg::no_tag;
        alu_result = '0;
        expect_result(4'd2, w);
    endtask

    task automatic test_order();
        lsq_pkg::data_t w;
        rand_word(w);
        dispatch(lsq_pkg::sw, 4'd6, 32'hc0, lsq_pkg::no_tag, w, '0);
        dispatch(lsq_pkg::lw, 4'd7, 32'hc0, lsq_pkg::no_tag, '0, '0);
        expect_commit_req(4'd6);
        check_quiet(10);
        commit(4'd6);
        expect_result(4'd6, '0);
        expect_result(4'd7, w);
    endtask

    task automatic test_full();
        lsq_pkg::data_t words [7];
        for (int i = 0; i < 7; i++) begin
            rand_word(words[i]);
        end
        dispatch(lsq_pkg::sw, 4'd1, 32'h100, lsq_pkg::no_tag, words[0], '0);
        expect_commit_req(4'd1);
        for (int i = 1; i < 7; i++) begin
            dispatch(lsq_pkg::sw, lsq_pkg::rob_tag_t'(i + 1), 32'h100 + 4 * i,
                     lsq_pkg::no_tag, words[i], '0);
        end
        check_bit("full", full, 1'b1);
        // must be dropped
        dispatch(lsq_pkg::sw, 4'd8, 32'h200, lsq_pkg::no_tag, 32'hffff_ffff, '0);
        check_bit("full", full, 1'b1);
        for (int i = 1; i <= 7; i++) begin
            commit(lsq_pkg::rob_tag_t'(i));
            // next request shows up before this store's result
            if (i < 7) begin
                expect_commit_req(lsq_pkg::rob_tag_t'(i + 1));
            end
            expect_result(lsq_pkg::rob_tag_t'(i), '0);
        end
        check_quiet(20);
        check_bit("full", full, 1'b0);
        for (int i = 0; i < 7; i++) begin
            run_load(lsq_pkg::lw, lsq_pkg::rob_tag_t'(i + 8), 32'h100 + 4 * i, '0, words[i]);
        end
    endtask

    task automatic test_flush();
        lsq_pkg::data_t w;
        rand_word(w);
        dispatch(lsq_pkg::sw, 4'd9, 32'h40, lsq_pkg::no_tag, w, '0);
        expect_commit_req(4'd9);
        // fill the buffer so the flush has to empty it
        for (int i = 1; i < 7; i++) begin
            dispatch(lsq_pkg::sw, lsq_pkg::rob_tag_t'(i + 9), 32'h40 + 4 * i,
                     lsq_pkg::no_tag, w, '0);
        end
        check_bit("full", full, 1'b1);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_bit("full", full, 1'b0);
        check_quiet(20);
        // flushed store never reached memory
        run_load(lsq_pkg::lw, 4'd11, 32'h40, '0, word_a);
    endtask

    initial begin
        rst_n        = 1'b0;
        disp_ena     = 1'b0;
        disp_op      = lsq_pkg::lb;
        disp_v1      = '0;
        disp_v2      = '0;
        disp_q1      = lsq_pkg::no_tag;
        disp_q2      = lsq_pkg::no_tag;
        disp_imm     = '0;
        disp_rob_id  = lsq_pkg::no_tag;
        alu_valid    = 1'b0;
        alu_tag      = lsq_pkg::no_tag;
        alu_result   = '0;
        commit_valid = 1'b0;
        commit_tag   = lsq_pkg::no_tag;
        flush        = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_store_load();
        test_alu_wakeup();
        test_order();
        test_full();
        test_flush();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- source/lsq_top.sv
`timescale 1ns/1ps

module lsq_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              disp_ena,
    input  lsq_pkg::ls_op_t   disp_op,
    input  lsq_pkg::data_t    disp_v1,
    input  lsq_pkg::data_t    disp_v2,
    input  lsq_pkg::rob_tag_t disp_q1,
    input  lsq_pkg::rob_tag_t disp_q2,
    input  lsq_pkg::data_t    disp_imm,
    input  lsq_pkg::rob_tag_t disp_rob_id,
    output logic              full,
    input  logic              alu_valid,
    input  lsq_pkg::rob_tag_t alu_tag,
    input  lsq_pkg::data_t    alu_result,
    input  logic              commit_valid,
    input  lsq_pkg::rob_tag_t commit_tag,
    input  logic              flush,
    output lsq_pkg::rob_tag_t store_commit_tag,
    output logic              ls_valid,
    output lsq_pkg::rob_tag_t ls_tag,
    output lsq_pkg::data_t    ls_result
);

    ls_dispatch_if disp_bus ();
    ls_req_if      req_bus ();

    logic               ex_busy;
    lsq_pkg::ram_addr_t ram_addr;
    lsq_pkg::data_t     ram_wdata;
    logic [3:0]         ram_we;
    lsq_pkg::data_t     ram_rdata;

    assign disp_bus.ena    = disp_ena;
    assign disp_bus.op     = disp_op;
    assign disp_bus.v1     = disp_v1;
    assign disp_bus.v2     = disp_v2;
    assign disp_bus.q1     = disp_q1;
    assign disp_bus.q2     = disp_q2;
    assign disp_bus.imm    = disp_imm;
    assign disp_bus.rob_id = disp_rob_id;

    ls_buffer u_buffer (
        .clk              (clk),
        .rst_n            (rst_n),
        .disp             (disp_bus),
        .full             (full),
        .req              (req_bus),
        .ex_busy          (ex_busy),
        .alu_valid        (alu_valid),
        .alu_tag          (alu_tag),
        .alu_result       (alu_result),
        .ls_valid         (ls_valid),
        .ls_tag           (ls_tag),
        .ls_result        (ls_result),
        .commit_valid     (commit_valid),
        .commit_tag       (commit_tag),
        .flush            (flush),
        .store_commit_tag (store_commit_tag)
    );

    ls_unit u_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_bus),
        .busy      (ex_busy),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .ls_valid  (ls_valid),
        .ls_tag    (ls_tag),
        .ls_result (ls_result)
    );

    data_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

//--- source/ls_buffer.sv
`timescale 1ns/1ps

module ls_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    ls_dispatch_if.receiver       disp,
    output logic                  full,
    ls_req_if.sender              req,
    input  logic                  ex_busy,
    input  logic                  alu_valid,
    input  lsq_pkg::rob_tag_t     alu_tag,
    input  lsq_pkg::data_t        alu_result,
    input  logic                  ls_valid,
    input  lsq_pkg::rob_tag_t     ls_tag,
    input  lsq_pkg::data_t        ls_result,
    input  logic                  commit_valid,
    input  lsq_pkg::rob_tag_t     commit_tag,
    input  logic                  flush,
    output lsq_pkg::rob_tag_t     store_commit_tag
);

    lsq_pkg::lsb_ptr_t head;
    lsq_pkg::lsb_ptr_t tail;

    logic              entry_valid [lsq_pkg::lsb_depth];
    logic              entry_committed [lsq_pkg::lsb_depth];
    lsq_pkg::ls_op_t   entry_op [lsq_pkg::lsb_depth];
    lsq_pkg::data_t    entry_v1 [lsq_pkg::lsb_depth];
    lsq_pkg::data_t    entry_v2 [lsq_pkg::lsb_depth];
    lsq_pkg::rob_tag_t entry_q1 [lsq_pkg::lsb_depth];
    lsq_pkg::rob_tag_t entry_q2 [lsq_pkg::lsb_depth];
    lsq_pkg::data_t    entry_imm [lsq_pkg::lsb_depth];
    lsq_pkg::rob_tag_t entry_rob_id [lsq_pkg::lsb_depth];

    // head store already asked the rob for its commit
    logic commit_sent;

    logic              head_ready;
    logic              head_is_load;
    lsq_pkg::data_t    in_v1;
    lsq_pkg::data_t    in_v2;
    lsq_pkg::rob_tag_t in_q1;
    lsq_pkg::rob_tag_t in_q2;

    // one slot stays empty so full and empty differ
    assign full = (lsq_pkg::lsb_ptr_t'(tail + 1'b1) == head);

    assign head_ready = entry_valid[head]
                        && (entry_q1[head] == lsq_pkg::no_tag)
                        && (entry_q2[head] == lsq_pkg::no_tag);
    assign head_is_load = (entry_op[head] <= lsq_pkg::lhu);

    // catch a result broadcast on the same edge as dispatch
    always_comb begin
        in_v1 = disp.v1;
        in_q1 = disp.q1;
        in_v2 = disp.v2;
        in_q2 = disp.q2;
        if (alu_valid && disp.q1 == alu_tag) begin
            in_v1 = alu_result;
            in_q1 = lsq_pkg::no_tag;
        end
        if (ls_valid && disp.q1 == ls_tag) begin
            in_v1 = ls_result;
            in_q1 = lsq_pkg::no_tag;
        end
        if (alu_valid && disp.q2 == alu_tag) begin
            in_v2 = alu_result;
            in_q2 = lsq_pkg::no_tag;
        end
        if (ls_valid && disp.q2 == ls_tag) begin
            in_v2 = ls_result;
            in_q2 = lsq_pkg::no_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head             <= '0;
            tail             <= '0;
            req.valid        <= 1'b0;
            store_commit_tag <= lsq_pkg::no_tag;
            commit_sent      <= 1'b0;
            for (int i = 0; i < lsq_pkg::lsb_depth; i++) begin
                entry_valid[i]     <= 1'b0;
                entry_committed[i] <= 1'b0;
            end
        end else if (flush) begin
            head             <= '0;
            tail             <= '0;
            req.valid        <= 1'b0;
            store_commit_tag <= lsq_pkg::no_tag;
            commit_sent      <= 1'b0;
            for (int i = 0; i < lsq_pkg::lsb_depth; i++) begin
                entry_valid[i]     <= 1'b0;
                entry_committed[i] <= 1'b0;
            end
        end else begin
            req.valid        <= 1'b0;
            store_commit_tag <= lsq_pkg::no_tag;

            // wakeup and commit marking
            for (int i = 0; i < lsq_pkg::lsb_depth; i++) begin
                if (alu_valid && entry_q1[i] == alu_tag) begin
                    entry_v1[i] <= alu_result;
                    entry_q1[i] <= lsq_pkg::no_tag;
                end
                if (ls_valid && entry_q1[i] == ls_tag) begin
                    entry_v1[i] <= ls_result;
                    entry_q1[i] <= lsq_pkg::no_tag;
                end
                if (alu_valid && entry_q2[i] == alu_tag) begin
                    entry_v2[i] <= alu_result;
                    entry_q2[i] <= lsq_pkg::no_tag;
                end
                if (ls_valid && entry_q2[i] == ls_tag) begin
                    entry_v2[i] <= ls_result;
                    entry_q2[i] <= lsq_pkg::no_tag;
                end
                if (commit_valid && entry_valid[i] && entry_rob_id[i] == commit_tag) begin
                    entry_committed[i] <= 1'b1;
                end
            end

            // issue from head only, stores wait for commit
            if (head_ready) begin
                if (head_is_load || entry_committed[head]) begin
                    if (!ex_busy && !req.valid) begin
                        req.valid          <= 1'b1;
                        req.op             <= entry_op[head];
                        req.addr           <= entry_v1[head] + entry_imm[head];
                        req.store_data     <= entry_v2[head];
                        req.rob_id         <= entry_rob_id[head];
                        entry_valid[head]  <= 1'b0;
                        head               <= head + 1'b1;
                        commit_sent        <= 1'b0;
                    end
                end else if (!commit_sent) begin
                    store_commit_tag <= entry_rob_id[head];
                    commit_sent      <= 1'b1;
                end
            end

            if (disp.ena && !full) begin
                entry_valid[tail]     <= 1'b1;
                entry_committed[tail] <= 1'b0;
                entry_op[tail]        <= disp.op;
                entry_v1[tail]        <= in_v1;
                entry_v2[tail]        <= in_v2;
                entry_q1[tail]        <= in_q1;
                entry_q2[tail]        <= in_q2;
                entry_imm[tail]       <= disp.imm;
                entry_rob_id[tail]    <= disp.rob_id;
                tail                  <= tail + 1'b1;
            end
        end
    end

endmodule

//--- source/ls_unit.sv
`timescale 1ns/1ps

module ls_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    ls_req_if.receiver            req,
    output logic                  busy,
    output lsq_pkg::ram_addr_t    ram_addr,
    output lsq_pkg::data_t        ram_wdata,
    output logic [3:0]            ram_we,
    input  lsq_pkg::data_t        ram_rdata,
    output logic                  ls_valid,
    output lsq_pkg::rob_tag_t     ls_tag,
    output lsq_pkg::data_t        ls_result
);

    // request in the ram read cycle
    logic              s1_valid;
    lsq_pkg::ls_op_t   s1_op;
    logic [1:0]        s1_off;
    lsq_pkg::rob_tag_t s1_tag;

    lsq_pkg::data_t    rd_shifted;
    lsq_pkg::data_t    load_value;

    // ram sees the request while valid is still up
    assign ram_addr = req.addr[9:2];
    assign busy     = req.valid | s1_valid;

    always_comb begin
        ram_wdata = req.store_data;
        ram_we    = 4'b0000;
        case (req.op)
            lsq_pkg::sb: begin
                ram_wdata = {4{req.store_data[7:0]}};
                ram_we    = 4'b0001 << req.addr[1:0];
            end
            lsq_pkg::sh: begin
                ram_wdata = {2{req.store_data[15:0]}};
                ram_we    = req.addr[1] ? 4'b1100 : 4'b0011;
            end
            lsq_pkg::sw: ram_we = 4'b1111;
            default:     ram_we = 4'b0000;
        endcase
        if (!req.valid) begin
            ram_we = 4'b0000;
        end
    end

    // move addressed byte or half down to bit 0
    assign rd_shifted = ram_rdata >> {s1_off, 3'b000};

    always_comb begin
        case (s1_op)
            lsq_pkg::lb:  load_value = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
            lsq_pkg::lh:  load_value = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
            lsq_pkg::lw:  load_value = ram_rdata;
            lsq_pkg::lbu: load_value = {24'd0, rd_shifted[7:0]};
            lsq_pkg::lhu: load_value = {16'd0, rd_shifted[15:0]};
            // stores report zero
            default:      load_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            ls_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            ls_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            s1_op  <= req.op;
            s1_off <= req.addr[1:0];
            s1_tag <= req.rob_id;
        end
        if (s1_valid) begin
            ls_tag    <= s1_tag;
            ls_result <= load_value;
        end
    end

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic               clk,
    input  lsq_pkg::ram_addr_t addr,
    input  lsq_pkg::data_t     wdata,
    input  logic [3:0]         we,
    output lsq_pkg::data_t     rdata
);

    lsq_pkg::data_t mem [lsq_pkg::ram_words];

    // byte lane writes, read returns the old word
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        rdata <= mem[addr];
    end

endmodule

//--- source/ls_req_if.sv
`timescale 1ns/1ps

interface ls_req_if;
    // valid is a single cycle pulse
    logic              valid;
    lsq_pkg::ls_op_t   op;
    lsq_pkg::data_t    addr;
    lsq_pkg::data_t    store_data;
    lsq_pkg::rob_tag_t rob_id;

    modport sender (
        output valid, op, addr, store_data, rob_id
    );

    modport receiver (
        input valid, op, addr, store_data, rob_id
    );
endinterface

//--- source/ls_dispatch_if.sv
`timescale 1ns/1ps

interface ls_dispatch_if;
    logic              ena;
    lsq_pkg::ls_op_t   op;
    lsq_pkg::data_t    v1;
    lsq_pkg::data_t    v2;
    lsq_pkg::rob_tag_t q1;
    lsq_pkg::rob_tag_t q2;
    lsq_pkg::data_t    imm;
    lsq_pkg::rob_tag_t rob_id;

    modport sender (
        output ena, op, v1, v2, q1, q2, imm, rob_id
    );

    modport receiver (
        input ena, op, v1, v2, q1, q2, imm, rob_id
    );
endinterface

//--- source/lsq_pkg.sv
package lsq_pkg;

    // operand, immediate, result and address word
    typedef logic [31:0] data_t;

    // reorder buffer tag, zero means no dependency
    typedef logic [3:0] rob_tag_t;

    localparam rob_tag_t no_tag = 4'd0;

    // loads first, so op <= lhu means load
    typedef enum logic [2:0] {
        lb,
        lh,
        lw,
        lbu,
        lhu,
        sb,
        sh,
        sw
    } ls_op_t;

    // buffer geometry
    localparam int lsb_depth = 8;

    typedef logic [2:0] lsb_ptr_t;

    // data ram, word index from byte address bits 9:2
    localparam int ram_words = 256;

    typedef logic [7:0] ram_addr_t;

endpackage
